// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --timescale 1ns/1ps -Wno-fatal
TOP       ?= tb_biriq_int_core
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := all tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only when the pass line shows up in the simulator output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: project.f
+incdir+rtl
rtl/biriq_pkg.sv
rtl/biriq_ifs.sv
rtl/biriq_decode.sv
rtl/biriq_execute.sv
rtl/biriq_result.sv
rtl/biriq_int_core.sv
tb/tb_clock_gen.sv
tb/tb_biriq_int_core.sv

// File: rtl/biriq_cfg.svh
// Core widths, register count and the RV32I opcode and funct encodings
`ifndef BIRIQ_CFG_SVH
`define BIRIQ_CFG_SVH

// Data path and register file geometry
`define BIRIQ_XLEN          32
`define BIRIQ_NUM_REGS      32
`define BIRIQ_REG_IDX_W     5

// Major opcodes accepted by the integer pipeline
`define BIRIQ_OPC_OP        7'b0110011
`define BIRIQ_OPC_OP_IMM    7'b0010011
`define BIRIQ_OPC_LUI       7'b0110111

// funct3 groups shared by OP and OP-IMM
`define BIRIQ_F3_ADD_SUB    3'b000
`define BIRIQ_F3_SLL        3'b001
`define BIRIQ_F3_SLT        3'b010
`define BIRIQ_F3_SLTU       3'b011
`define BIRIQ_F3_XOR        3'b100
`define BIRIQ_F3_SRL_SRA    3'b101
`define BIRIQ_F3_OR         3'b110
`define BIRIQ_F3_AND        3'b111

// The alternate funct7 value selects SUB and SRA
`define BIRIQ_F7_BASE       7'b0000000
`define BIRIQ_F7_ALT        7'b0100000

`endif

// File: rtl/biriq_decode.sv
// Decode stage that splits an RV32I word into ALU controls, operands and an immediate
`include "biriq_cfg.svh"

module biriq_decode (
    input  logic                cpu_clock_i,
    input  logic                rst_n_i,
    input  logic                ins_valid_i,
    input  biriq_pkg::insn_t    ins_word_i,
    dec_if.source               dec
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    biriq_pkg::reg_idx_t    rs1_f;
    biriq_pkg::reg_idx_t    rs2_f;
    biriq_pkg::reg_idx_t    rd_f;
    biriq_pkg::xlen_t       i_imm;
    biriq_pkg::xlen_t       u_imm;
    logic                   f7_base;
    logic                   f7_alt;
    logic                   sub_sel;
    biriq_pkg::alu_op_t     f3_op;
    biriq_pkg::alu_op_t     op_d;
    biriq_pkg::xlen_t       imm_d;
    logic                   use_imm_d;
    logic                   legal_d;

    assign opcode = ins_word_i[6:0];
    assign rd_f   = ins_word_i[11:7];
    assign funct3 = ins_word_i[14:12];
    assign rs1_f  = ins_word_i[19:15];
    assign rs2_f  = ins_word_i[24:20];
    assign funct7 = ins_word_i[31:25];

    assign i_imm = {{20{ins_word_i[31]}}, ins_word_i[31:20]};
    assign u_imm = {ins_word_i[31:12], 12'b0};

    assign f7_base = (funct7 == `BIRIQ_F7_BASE);
    assign f7_alt  = (funct7 == `BIRIQ_F7_ALT);

    // ADDI has no SUB form, bit 30 there is just part of the immediate
    assign sub_sel = f7_alt && (opcode == `BIRIQ_OPC_OP);

    always_comb begin
        case (funct3)
            `BIRIQ_F3_ADD_SUB: f3_op = sub_sel ? biriq_pkg::ALU_SUB : biriq_pkg::ALU_ADD;
            `BIRIQ_F3_SLL:     f3_op = biriq_pkg::ALU_SLL;
            `BIRIQ_F3_SLT:     f3_op = biriq_pkg::ALU_SLT;
            `BIRIQ_F3_SLTU:    f3_op = biriq_pkg::ALU_SLTU;
            `BIRIQ_F3_XOR:     f3_op = biriq_pkg::ALU_XOR;
            `BIRIQ_F3_SRL_SRA: f3_op = f7_alt ? biriq_pkg::ALU_SRA : biriq_pkg::ALU_SRL;
            `BIRIQ_F3_OR:      f3_op = biriq_pkg::ALU_OR;
            default:           f3_op = biriq_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        op_d      = f3_op;
        imm_d     = i_imm;
        use_imm_d = 1'b0;
        legal_d   = 1'b0;
        case (opcode)
            `BIRIQ_OPC_OP: begin
                // Only ADD/SUB and SRL/SRA have an alternate funct7 encoding
                legal_d = f7_base || (f7_alt && ((funct3 == `BIRIQ_F3_ADD_SUB) ||
                                                 (funct3 == `BIRIQ_F3_SRL_SRA)));
            end
            `BIRIQ_OPC_OP_IMM: begin
                use_imm_d = 1'b1;
                if (funct3 == `BIRIQ_F3_SLL) begin
                    legal_d = f7_base;
                end else if (funct3 == `BIRIQ_F3_SRL_SRA) begin
                    legal_d = f7_base || f7_alt;
                end else begin
                    legal_d = 1'b1;
                end
            end
            `BIRIQ_OPC_LUI: begin
                op_d      = biriq_pkg::ALU_PASS_B;
                imm_d     = u_imm;
                use_imm_d = 1'b1;
                legal_d   = 1'b1;
            end
            default: begin
                legal_d = 1'b0;
            end
        endcase
    end

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec.valid   <= 1'b0;
            dec.rd_we   <= 1'b0;
            dec.illegal <= 1'b0;
        end else begin
            dec.valid   <= ins_valid_i;
            dec.rd_we   <= ins_valid_i && legal_d && (rd_f != '0);
            dec.illegal <= ins_valid_i && !legal_d;
        end
    end

    // Payload fields are only looked at while valid is set
    always_ff @(posedge cpu_clock_i) begin
        dec.op      <= op_d;
        dec.rs1     <= rs1_f;
        dec.rs2     <= rs2_f;
        dec.rd      <= rd_f;
        dec.imm     <= imm_d;
        dec.use_imm <= use_imm_d;
    end

endmodule

// File: rtl/biriq_execute.sv
// Execute stage with operand read, forwarding from the previous result and the ALU
module biriq_execute (
    input  logic    cpu_clock_i,
    input  logic    rst_n_i,
    dec_if.sink     dec,
    rf_if.requester rf,
    res_if.source   res
);

    logic                   fwd_rs1;
    logic                   fwd_rs2;
    biriq_pkg::xlen_t       op_a;
    biriq_pkg::xlen_t       rs2_val;
    biriq_pkg::xlen_t       op_b;
    logic [4:0]             shamt;
    biriq_pkg::xlen_t       alu_res;

    assign rf.rs1_addr = dec.rs1;
    assign rf.rs2_addr = dec.rs2;

    // The register file already holds everything two or more steps older,
    // so only the instruction sitting in our own output register needs a bypass
    assign fwd_rs1 = res.valid && res.rd_we && (res.rd == dec.rs1);
    assign fwd_rs2 = res.valid && res.rd_we && (res.rd == dec.rs2);

    assign op_a    = fwd_rs1 ? res.data : rf.rs1_data;
    assign rs2_val = fwd_rs2 ? res.data : rf.rs2_data;
    assign op_b    = dec.use_imm ? dec.imm : rs2_val;

    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.op)
            biriq_pkg::ALU_ADD:  alu_res = op_a + op_b;
            biriq_pkg::ALU_SUB:  alu_res = op_a - op_b;
            biriq_pkg::ALU_SLL:  alu_res = op_a << shamt;
            biriq_pkg::ALU_SLT: begin
                alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            end
            biriq_pkg::ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            biriq_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            biriq_pkg::ALU_SRL:  alu_res = op_a >> shamt;
            biriq_pkg::ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
            biriq_pkg::ALU_OR:   alu_res = op_a | op_b;
            biriq_pkg::ALU_AND:  alu_res = op_a & op_b;
            default:             alu_res = op_b;
        endcase
    end

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res.valid   <= 1'b0;
            res.rd_we   <= 1'b0;
            res.illegal <= 1'b0;
        end else begin
            res.valid   <= dec.valid;
            res.rd_we   <= dec.valid && dec.rd_we;
            res.illegal <= dec.valid && dec.illegal;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        res.rd   <= dec.rd;
        res.data <= alu_res;
    end

endmodule

// File: rtl/biriq_ifs.sv
// Interfaces dec_if, rf_if and res_if between the pipeline stages, with their modports

// Decoded instruction from decode to execute
interface dec_if;
    logic                   valid;
    biriq_pkg::alu_op_t     op;
    biriq_pkg::reg_idx_t    rs1;
    biriq_pkg::reg_idx_t    rs2;
    biriq_pkg::reg_idx_t    rd;
    biriq_pkg::xlen_t       imm;
    logic                   use_imm;
    logic                   rd_we;
    logic                   illegal;

    modport source (output valid, op, rs1, rs2, rd, imm, use_imm, rd_we, illegal);
    modport sink   (input  valid, op, rs1, rs2, rd, imm, use_imm, rd_we, illegal);
endinterface

// Two combinational register file read ports
interface rf_if;
    biriq_pkg::reg_idx_t    rs1_addr;
    biriq_pkg::reg_idx_t    rs2_addr;
    biriq_pkg::xlen_t       rs1_data;
    biriq_pkg::xlen_t       rs2_data;

    modport requester (output rs1_addr, rs2_addr, input  rs1_data, rs2_data);
    modport provider  (input  rs1_addr, rs2_addr, output rs1_data, rs2_data);
endinterface

// Execute outcome handed to the result stage
interface res_if;
    logic                   valid;
    biriq_pkg::reg_idx_t    rd;
    logic                   rd_we;
    biriq_pkg::xlen_t       data;
    logic                   illegal;

    modport source (output valid, rd, rd_we, data, illegal);
    modport sink   (input  valid, rd, rd_we, data, illegal);
endinterface

// File: rtl/biriq_int_core.sv
// Top level of the three-stage integer pipeline, wiring decode, execute and result
module biriq_int_core (
    input  logic                    cpu_clock_i,
    input  logic                    rst_n_i,
    input  logic                    ins_valid_i,
    input  biriq_pkg::insn_t        ins_word_i,
    output logic                    wb_valid_o,
    output biriq_pkg::reg_idx_t     wb_dest_o,
    output biriq_pkg::xlen_t        wb_data_o,
    output logic                    excp_o,
    output biriq_pkg::xlen_t        retired_count_o
);

    dec_if dec_bus ();
    rf_if  rf_bus ();
    res_if res_bus ();

    biriq_decode u_decode (
        .cpu_clock_i (cpu_clock_i),
        .rst_n_i     (rst_n_i),
        .ins_valid_i (ins_valid_i),
        .ins_word_i  (ins_word_i),
        .dec         (dec_bus.source)
    );

    // Execute reads the register file of the result stage and bypasses its own output
    biriq_execute u_execute (
        .cpu_clock_i (cpu_clock_i),
        .rst_n_i     (rst_n_i),
        .dec         (dec_bus.sink),
        .rf          (rf_bus.requester),
        .res         (res_bus.source)
    );

    biriq_result u_result (
        .cpu_clock_i     (cpu_clock_i),
        .rst_n_i         (rst_n_i),
        .res             (res_bus.sink),
        .rf              (rf_bus.provider),
        .wb_valid_o      (wb_valid_o),
        .wb_dest_o       (wb_dest_o),
        .wb_data_o       (wb_data_o),
        .excp_o          (excp_o),
        .retired_count_o (retired_count_o)
    );

endmodule

// File: rtl/biriq_pkg.sv
// Package with the data word, register index and instruction types and the ALU operation enum
`include "biriq_cfg.svh"

package biriq_pkg;

    // Operands, results and the retired counter
    typedef logic [`BIRIQ_XLEN-1:0] xlen_t;

    // Architectural register index
    typedef logic [`BIRIQ_REG_IDX_W-1:0] reg_idx_t;

    // Raw 32-bit instruction word
    typedef logic [31:0] insn_t;

    // LUI goes through the ALU as PASS_B with the U-type immediate
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

endpackage

// File: rtl/biriq_result.sv
// Result stage with the register file, writeback and exception outputs and the retired counter
`include "biriq_cfg.svh"

module biriq_result (
    input  logic                    cpu_clock_i,
    input  logic                    rst_n_i,
    res_if.sink                     res,
    rf_if.provider                  rf,
    output logic                    wb_valid_o,
    output biriq_pkg::reg_idx_t     wb_dest_o,
    output biriq_pkg::xlen_t        wb_data_o,
    output logic                    excp_o,
    output biriq_pkg::xlen_t        retired_count_o
);

    biriq_pkg::xlen_t   regs [`BIRIQ_NUM_REGS];
    logic               wr_en;
    logic               retire;

    assign wr_en  = res.valid && res.rd_we;
    assign retire = res.valid && !res.illegal;

    // Architectural state starts out all zero
    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BIRIQ_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[res.rd] <= res.data;
        end
    end

    // x0 is hardwired, whatever the array holds
    assign rf.rs1_data = (rf.rs1_addr == '0) ? '0 : regs[rf.rs1_addr];
    assign rf.rs2_data = (rf.rs2_addr == '0) ? '0 : regs[rf.rs2_addr];

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_o      <= 1'b0;
            excp_o          <= 1'b0;
            retired_count_o <= '0;
        end else begin
            wb_valid_o <= wr_en;
            excp_o     <= res.valid && res.illegal;
            // Writes to x0 still count as retired
            if (retire) begin
                retired_count_o <= retired_count_o + 1'b1;
            end
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        wb_dest_o <= res.rd;
        wb_data_o <= res.data;
    end

endmodule

// File: tb/tb_biriq_int_core.sv
// Testbench top with random RV32I stimulus, a reference model, compare tasks and a timeout
`include "biriq_cfg.svh"

module tb_biriq_int_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES   = 5;
    localparam int ISSUE_CYCLES   = 2000;
    localparam int TAIL_CYCLES    = 8;
    localparam int DRAIN_CYCLES   = 50;
    localparam int PIPE_DEPTH     = 3;
    localparam int TIMEOUT_CYCLES = ISSUE_CYCLES + RESET_CYCLES + DRAIN_CYCLES;

    // Major opcodes as the RV32I base encoding defines them
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // What the DUT outputs should show three edges after an issue slot
    typedef struct packed {
        logic                   wb_valid;
        biriq_pkg::reg_idx_t    dest;
        biriq_pkg::xlen_t       data;
        logic                   excp;
        biriq_pkg::xlen_t       count;
    } outcome_t;

    logic                   cpu_clock;
    logic                   rst_n;
    logic                   ins_valid;
    biriq_pkg::insn_t       ins_word;
    logic                   wb_valid;
    biriq_pkg::reg_idx_t    wb_dest;
    biriq_pkg::xlen_t       wb_data;
    logic                   excp;
    biriq_pkg::xlen_t       retired_count;

    biriq_pkg::xlen_t       model_regs [`BIRIQ_NUM_REGS];
    biriq_pkg::xlen_t       model_count;
    biriq_pkg::xlen_t       exp_count;
    outcome_t               exp_q [$];
    outcome_t               pending;
    outcome_t               due_out;
    biriq_pkg::insn_t       gen_word;
    logic [31:0]            gen_rnd;
    int                     wb_errors;
    int                     flag_errors;
    int                     count_errors;
    int                     cycle_count = 0;

    tb_clock_gen #(
        .PERIOD_NS    (4),
        .RESET_CYCLES (RESET_CYCLES)
    ) clock_gen (
        .clk_o   (cpu_clock),
        .rst_n_o (rst_n)
    );

    biriq_int_core DUT (
        .cpu_clock_i     (cpu_clock),
        .rst_n_i         (rst_n),
        .ins_valid_i     (ins_valid),
        .ins_word_i      (ins_word),
        .wb_valid_o      (wb_valid),
        .wb_dest_o       (wb_dest),
        .wb_data_o       (wb_data),
        .excp_o          (excp),
        .retired_count_o (retired_count)
    );

    function automatic biriq_pkg::xlen_t model_alu(input biriq_pkg::alu_op_t op,
                                                   input biriq_pkg::xlen_t a,
                                                   input biriq_pkg::xlen_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            biriq_pkg::ALU_ADD:  return a + b;
            biriq_pkg::ALU_SUB:  return a - b;
            biriq_pkg::ALU_SLL:  return a << sh;
            biriq_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            biriq_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            biriq_pkg::ALU_XOR:  return a ^ b;
            biriq_pkg::ALU_SRL:  return a >> sh;
            biriq_pkg::ALU_SRA:  return $signed(a) >>> sh;
            biriq_pkg::ALU_OR:   return a | b;
            biriq_pkg::ALU_AND:  return a & b;
            default:             return b;
        endcase
    endfunction

    // Three picks in four land on x0..x3 so hazards and x0 targets come up often
    function automatic biriq_pkg::reg_idx_t pick_reg();
        logic [31:0] r;
        r = $urandom;
        if (r[9:8] != 2'b00) begin
            return {3'b000, r[1:0]};
        end
        return r[4:0];
    endfunction

    function automatic outcome_t idle_outcome();
        outcome_t out;
        out       = '0;
        out.count = model_count;
        return out;
    endfunction

    // Builds one instruction and runs it through the model in program order
    task automatic make_insn(output biriq_pkg::insn_t word, output outcome_t out);
        logic [31:0]            kind;
        logic [31:0]            sel;
        logic [31:0]            rnd;
        biriq_pkg::reg_idx_t    rd;
        biriq_pkg::reg_idx_t    rs1;
        biriq_pkg::reg_idx_t    rs2;
        biriq_pkg::alu_op_t     op;
        biriq_pkg::xlen_t       b;
        biriq_pkg::xlen_t       res;
        logic [11:0]            imm12;
        logic [2:0]             f3;
        logic [6:0]             f7;
        logic [6:0]             opc;
        logic                   legal;
        kind  = $urandom % 32'd100;
        sel   = $urandom;
        rnd   = $urandom;
        rd    = pick_reg();
        rs1   = pick_reg();
        rs2   = pick_reg();
        legal = 1'b1;
        op    = biriq_pkg::ALU_ADD;
        b     = '0;
        f3    = 3'b000;
        f7    = 7'h00;
        if (kind < 32'd45) begin
            case (sel % 32'd10)
                0:       begin op = biriq_pkg::ALU_ADD;  f3 = 3'b000; end
                1:       begin op = biriq_pkg::ALU_SUB;  f3 = 3'b000; f7 = 7'h20; end
                2:       begin op = biriq_pkg::ALU_SLL;  f3 = 3'b001; end
                3:       begin op = biriq_pkg::ALU_SLT;  f3 = 3'b010; end
                4:       begin op = biriq_pkg::ALU_SLTU; f3 = 3'b011; end
                5:       begin op = biriq_pkg::ALU_XOR;  f3 = 3'b100; end
                6:       begin op = biriq_pkg::ALU_SRL;  f3 = 3'b101; end
                7:       begin op = biriq_pkg::ALU_SRA;  f3 = 3'b101; f7 = 7'h20; end
                8:       begin op = biriq_pkg::ALU_OR;   f3 = 3'b110; end
                default: begin op = biriq_pkg::ALU_AND;  f3 = 3'b111; end
            endcase
            b    = model_regs[rs2];
            word = {f7, rs2, rs1, f3, rd, OPC_OP};
        end else if (kind < 32'd80) begin
            imm12 = rnd[11:0];
            case (sel % 32'd9)
                0:       begin op = biriq_pkg::ALU_ADD;  f3 = 3'b000; end
                1:       begin op = biriq_pkg::ALU_SLT;  f3 = 3'b010; end
                2:       begin op = biriq_pkg::ALU_SLTU; f3 = 3'b011; end
                3:       begin op = biriq_pkg::ALU_XOR;  f3 = 3'b100; end
                4:       begin op = biriq_pkg::ALU_OR;   f3 = 3'b110; end
                5:       begin op = biriq_pkg::ALU_AND;  f3 = 3'b111; end
                6:       begin op = biriq_pkg::ALU_SLL;  f3 = 3'b001; imm12 = {7'h00, rnd[4:0]}; end
                7:       begin op = biriq_pkg::ALU_SRL;  f3 = 3'b101; imm12 = {7'h00, rnd[4:0]}; end
                default: begin op = biriq_pkg::ALU_SRA;  f3 = 3'b101; imm12 = {7'h20, rnd[4:0]}; end
            endcase
            b    = {{20{imm12[11]}}, imm12};
            word = {imm12, rs1, f3, rd, OPC_OP_IMM};
        end else if (kind < 32'd90) begin
            op   = biriq_pkg::ALU_PASS_B;
            b    = {rnd[31:12], 12'b0};
            word = {rnd[31:12], rd, OPC_LUI};
        end else begin
            legal = 1'b0;
            if (sel[0]) begin
                // OP with a funct7 that no RV32I instruction uses
                f7 = rnd[31:25];
                if (f7 == 7'h00 || f7 == 7'h20) begin
                    f7 = f7 ^ 7'h01;
                end
                word = {f7, rs2, rs1, rnd[14:12], rd, OPC_OP};
            end else begin
                opc = rnd[6:0];
                if (opc == OPC_OP || opc == OPC_OP_IMM || opc == OPC_LUI) begin
                    opc = opc ^ 7'b1000000;
                end
                word = {rnd[31:7], opc};
            end
        end
        out = idle_outcome();
        if (legal) begin
            res         = model_alu(op, model_regs[rs1], b);
            model_count = model_count + 32'd1;
            if (rd != '0) begin
                model_regs[rd] = res;
            end
            out.wb_valid = (rd != '0);
            out.dest     = rd;
            out.data     = res;
            out.count    = model_count;
        end else begin
            out.excp = 1'b1;
        end
    endtask

    task automatic check_wb(input biriq_pkg::reg_idx_t exp_dest, input biriq_pkg::xlen_t exp_data);
        if (wb_dest !== exp_dest) begin
            $display("Error at %0t ns: wb_dest_o expected %0d, got %0d", $time, exp_dest, wb_dest);
            wb_errors = wb_errors + 1;
        end
        if (wb_data !== exp_data) begin
            $display("Error at %0t ns: wb_data_o expected %h, got %h", $time, exp_data, wb_data);
            wb_errors = wb_errors + 1;
        end
    endtask

    task automatic check_flag(input string sig_name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("Error at %0t ns: %s expected %b, got %b", $time, sig_name, exp_val, act_val);
            flag_errors = flag_errors + 1;
        end
    endtask

    task automatic check_count(input biriq_pkg::xlen_t exp_val);
        if (retired_count !== exp_val) begin
            $display("Error at %0t ns: retired_count_o expected %0d, got %0d",
                     $time, exp_val, retired_count);
            count_errors = count_errors + 1;
        end
    endtask

    initial begin
        ins_valid    = 1'b0;
        ins_word     = '0;
        wb_errors    = 0;
        flag_errors  = 0;
        count_errors = 0;
        model_count  = '0;
        exp_count    = '0;
        void'($urandom(66));
        for (int r = 0; r < `BIRIQ_NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        @(posedge rst_n);
        for (int i = 0; i < ISSUE_CYCLES + TAIL_CYCLES; i++) begin
            @(posedge cpu_clock);
            gen_rnd = $urandom % 32'd100;
            if (i < ISSUE_CYCLES && gen_rnd < 32'd80) begin
                make_insn(gen_word, pending);
                ins_valid <= 1'b1;
                ins_word  <= gen_word;
            end else begin
                pending   = idle_outcome();
                ins_valid <= 1'b0;
                ins_word  <= $urandom;
            end
            // The slot driven at this edge is due after the third edge from here
            exp_q.push_back(pending);
        end
        @(posedge cpu_clock);
        $display("Errors: writeback %0d, flags %0d, retired count %0d",
                 wb_errors, flag_errors, count_errors);
        if (wb_errors + flag_errors + count_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Outputs are compared on the falling edge, half a cycle after they settle
    always @(negedge cpu_clock) begin
        if (exp_q.size() > PIPE_DEPTH) begin
            due_out   = exp_q.pop_front();
            exp_count = due_out.count;
            check_flag("wb_valid_o", due_out.wb_valid, wb_valid);
            check_flag("excp_o", due_out.excp, excp);
            if (due_out.wb_valid) begin
                check_wb(due_out.dest, due_out.data);
            end
        end else begin
            check_flag("wb_valid_o", 1'b0, wb_valid);
            check_flag("excp_o", 1'b0, excp);
        end
        check_count(exp_count);
    end

    always @(posedge cpu_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

endmodule

// File: tb/tb_clock_gen.sv
// Testbench clock and reset generator for the integer pipeline
module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset is released on a rising edge, so the first sampling edge is the one after
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule
